/* hdl/cc_cfg_pkg.sv */
// Core complex fabric configuration
// Bus widths, accelerator port count and the data address map

package cc_cfg_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 5;

  // Accelerator offload ports
  localparam int unsigned NumAccPorts = 4;
  localparam int unsigned AccSelWidth = 2;

  // --------------------------------------------------------------------------
  // Data address map
  // --------------------------------------------------------------------------
  // TCDM window is 2**TcdmAddrWidth bytes, aligned to its own size
  localparam int unsigned          TcdmAddrWidth  = 12;
  localparam logic [AddrWidth-1:0] TcdmAliasStart = 32'h7000_0000;

  // Outstanding data requests and the order queue sizing
  localparam int unsigned RspOrderDepth = 4;
  localparam int unsigned OrderPtrWidth = $clog2(RspOrderDepth);
  localparam int unsigned OrderCntWidth = OrderPtrWidth + 1;

endpackage

/* hdl/cc_types_pkg.sv */
// Core complex fabric types
// Payload types of the offload and data streams

package cc_types_pkg;

  import cc_cfg_pkg::*;

  // Data stream payload
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Offload stream payload
  typedef logic [IdWidth-1:0]     acc_id_t;
  typedef logic [AccSelWidth-1:0] acc_sel_t;

  // Where a data request ends up
  typedef enum logic {
    MEM_SOC  = 1'b0,
    MEM_TCDM = 1'b1
  } mem_dst_e;

endpackage

/* hdl/offload_demux.sv */
// Offload request demultiplexer
// Raises the valid of the one accelerator port named by the target field
// and returns that port's ready to the core

`timescale 1ns/1ps

module offload_demux
  import cc_cfg_pkg::*;
  import cc_types_pkg::*;
(
  input  logic                   acc_q_valid_i,
  output logic                   acc_q_ready_o,
  input  acc_sel_t               acc_q_sel_i,
  output logic [NumAccPorts-1:0] acc_port_q_valid_o,
  input  logic [NumAccPorts-1:0] acc_port_q_ready_i
);

  // One-hot valid toward the selected port only
  always_comb begin
    acc_port_q_valid_o              = '0;
    acc_port_q_valid_o[acc_q_sel_i] = acc_q_valid_i;
  end

  // Ready comes back from the same port
  assign acc_q_ready_o = acc_port_q_ready_i[acc_q_sel_i];

endmodule

/* hdl/offload_rsp_arbiter.sv */
// Offload response arbiter
// Round-robin merge of the accelerator response streams toward the core

`timescale 1ns/1ps

module offload_rsp_arbiter
  import cc_cfg_pkg::*;
  import cc_types_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Accelerator side
  input  logic    [NumAccPorts-1:0] acc_port_p_valid_i,
  output logic    [NumAccPorts-1:0] acc_port_p_ready_o,
  input  acc_id_t [NumAccPorts-1:0] acc_port_p_id_i,
  input  data_t   [NumAccPorts-1:0] acc_port_p_data_i,
  input  logic    [NumAccPorts-1:0] acc_port_p_error_i,
  // Core side
  output logic                      acc_p_valid_o,
  input  logic                      acc_p_ready_i,
  output acc_id_t                   acc_p_id_o,
  output data_t                     acc_p_data_o,
  output logic                      acc_p_error_o
);

  acc_sel_t rr_ptr_q;
  acc_sel_t grant_idx;
  logic     grant_found;

  // Search upward from the pointer, wrapping around
  always_comb begin
    acc_sel_t cand_idx;
    grant_found = 1'b0;
    grant_idx   = rr_ptr_q;
    for (int unsigned i = 0; i < NumAccPorts; i++) begin
      cand_idx = acc_sel_t'(rr_ptr_q + i);
      if (!grant_found && acc_port_p_valid_i[cand_idx]) begin
        grant_found = 1'b1;
        grant_idx   = cand_idx;
      end
    end
  end

  // Granted payload to the core
  assign acc_p_valid_o = grant_found;
  assign acc_p_id_o    = acc_port_p_id_i[grant_idx];
  assign acc_p_data_o  = acc_port_p_data_i[grant_idx];
  assign acc_p_error_o = acc_port_p_error_i[grant_idx];

  // Only the granted port sees ready
  always_comb begin
    acc_port_p_ready_o            = '0;
    acc_port_p_ready_o[grant_idx] = grant_found & acc_p_ready_i;
  end

  // Priority moves past the winner on every handshake
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_ptr_q <= '0;
    end else if (acc_p_valid_o && acc_p_ready_i) begin
      rr_ptr_q <= grant_idx + 1'b1;
    end
  end

endmodule

/* hdl/data_addr_router.sv */
// Data address router
// Decodes each request against the TCDM and alias windows, steers it to
// the TCDM or SoC port and returns the responses in request order

`timescale 1ns/1ps

module data_addr_router
  import cc_cfg_pkg::*;
  import cc_types_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  addr_t tcdm_base_i,
  // Core side
  input  logic  mem_q_valid_i,
  output logic  mem_q_ready_o,
  input  addr_t mem_q_addr_i,
  input  logic  mem_q_write_i,
  input  data_t mem_q_wdata_i,
  output logic  mem_p_valid_o,
  input  logic  mem_p_ready_i,
  output data_t mem_p_rdata_o,
  // TCDM side
  output logic  tcdm_q_valid_o,
  input  logic  tcdm_q_ready_i,
  output addr_t tcdm_q_addr_o,
  output logic  tcdm_q_write_o,
  output data_t tcdm_q_wdata_o,
  input  logic  tcdm_p_valid_i,
  output logic  tcdm_p_ready_o,
  input  data_t tcdm_p_rdata_i,
  // SoC side
  output logic  soc_q_valid_o,
  input  logic  soc_q_ready_i,
  output addr_t soc_q_addr_o,
  output logic  soc_q_write_o,
  output data_t soc_q_wdata_o,
  input  logic  soc_p_valid_i,
  output logic  soc_p_ready_o,
  input  data_t soc_p_rdata_i
);

  mem_dst_e                 req_dst;
  mem_dst_e                 head_dst;
  logic                     hit_base;
  logic                     hit_alias;
  logic                     q_full;
  logic                     q_empty;
  logic                     push;
  logic                     pop;
  mem_dst_e                 dst_q [RspOrderDepth];
  logic [OrderPtrWidth-1:0] wr_ptr_q;
  logic [OrderPtrWidth-1:0] rd_ptr_q;
  logic [OrderCntWidth-1:0] count_q;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  assign hit_base  = mem_q_addr_i[AddrWidth-1:TcdmAddrWidth]
                     == tcdm_base_i[AddrWidth-1:TcdmAddrWidth];
  assign hit_alias = mem_q_addr_i[AddrWidth-1:TcdmAddrWidth]
                     == TcdmAliasStart[AddrWidth-1:TcdmAddrWidth];
  assign req_dst   = (hit_base || hit_alias) ? MEM_TCDM : MEM_SOC;

  // --------------------------------------------------------------------------
  // Request steering
  // --------------------------------------------------------------------------
  assign q_full  = (count_q == OrderCntWidth'(RspOrderDepth));
  assign q_empty = (count_q == '0);

  // Nothing leaves while the order queue cannot take another entry
  assign tcdm_q_valid_o = mem_q_valid_i & ~q_full & (req_dst == MEM_TCDM);
  assign soc_q_valid_o  = mem_q_valid_i & ~q_full & (req_dst == MEM_SOC);
  assign mem_q_ready_o  = ~q_full &
                          ((req_dst == MEM_TCDM) ? tcdm_q_ready_i : soc_q_ready_i);

  // Payload is shared by both sides
  assign tcdm_q_addr_o  = mem_q_addr_i;
  assign tcdm_q_write_o = mem_q_write_i;
  assign tcdm_q_wdata_o = mem_q_wdata_i;
  assign soc_q_addr_o   = mem_q_addr_i;
  assign soc_q_write_o  = mem_q_write_i;
  assign soc_q_wdata_o  = mem_q_wdata_i;

  // --------------------------------------------------------------------------
  // Response ordering
  // --------------------------------------------------------------------------
  assign head_dst = dst_q[rd_ptr_q];

  // Only the side at the head may answer
  assign mem_p_valid_o  = ~q_empty &
                          ((head_dst == MEM_TCDM) ? tcdm_p_valid_i : soc_p_valid_i);
  assign mem_p_rdata_o  = (head_dst == MEM_TCDM) ? tcdm_p_rdata_i : soc_p_rdata_i;
  assign tcdm_p_ready_o = ~q_empty & (head_dst == MEM_TCDM) & mem_p_ready_i;
  assign soc_p_ready_o  = ~q_empty & (head_dst == MEM_SOC) & mem_p_ready_i;

  assign push = mem_q_valid_i & mem_q_ready_o;
  assign pop  = mem_p_valid_o & mem_p_ready_i;

  // Destination storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      dst_q[wr_ptr_q] <= req_dst;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* hdl/core_complex_fabric.sv */
// Core complex routing fabric
// Offload steering and response merge plus the data memory router

`timescale 1ns/1ps

module core_complex_fabric
  import cc_cfg_pkg::*;
  import cc_types_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  addr_t                     tcdm_base_i,
  // Offload request from the core
  input  logic                      acc_q_valid_i,
  output logic                      acc_q_ready_o,
  input  acc_sel_t                  acc_q_sel_i,
  input  acc_id_t                   acc_q_id_i,
  input  data_t                     acc_q_data_i,
  // Offload requests to the accelerators
  output logic    [NumAccPorts-1:0] acc_port_q_valid_o,
  input  logic    [NumAccPorts-1:0] acc_port_q_ready_i,
  output acc_id_t [NumAccPorts-1:0] acc_port_q_id_o,
  output data_t   [NumAccPorts-1:0] acc_port_q_data_o,
  // Offload responses from the accelerators
  input  logic    [NumAccPorts-1:0] acc_port_p_valid_i,
  output logic    [NumAccPorts-1:0] acc_port_p_ready_o,
  input  acc_id_t [NumAccPorts-1:0] acc_port_p_id_i,
  input  data_t   [NumAccPorts-1:0] acc_port_p_data_i,
  input  logic    [NumAccPorts-1:0] acc_port_p_error_i,
  // Offload response to the core
  output logic                      acc_p_valid_o,
  input  logic                      acc_p_ready_i,
  output acc_id_t                   acc_p_id_o,
  output data_t                     acc_p_data_o,
  output logic                      acc_p_error_o,
  // Data stream from the core
  input  logic                      mem_q_valid_i,
  output logic                      mem_q_ready_o,
  input  addr_t                     mem_q_addr_i,
  input  logic                      mem_q_write_i,
  input  data_t                     mem_q_wdata_i,
  output logic                      mem_p_valid_o,
  input  logic                      mem_p_ready_i,
  output data_t                     mem_p_rdata_o,
  // TCDM port
  output logic                      tcdm_q_valid_o,
  input  logic                      tcdm_q_ready_i,
  output addr_t                     tcdm_q_addr_o,
  output logic                      tcdm_q_write_o,
  output data_t                     tcdm_q_wdata_o,
  input  logic                      tcdm_p_valid_i,
  output logic                      tcdm_p_ready_o,
  input  data_t                     tcdm_p_rdata_i,
  // SoC port
  output logic                      soc_q_valid_o,
  input  logic                      soc_q_ready_i,
  output addr_t                     soc_q_addr_o,
  output logic                      soc_q_write_o,
  output data_t                     soc_q_wdata_o,
  input  logic                      soc_p_valid_i,
  output logic                      soc_p_ready_o,
  input  data_t                     soc_p_rdata_i
);

  // Offload payload goes to every accelerator, only valid is steered
  assign acc_port_q_id_o   = {NumAccPorts{acc_q_id_i}};
  assign acc_port_q_data_o = {NumAccPorts{acc_q_data_i}};

  // --------------------------------------------------------------------------
  // Offload path
  // --------------------------------------------------------------------------
  offload_demux u_offload_demux (
    .acc_q_valid_i      (acc_q_valid_i),
    .acc_q_ready_o      (acc_q_ready_o),
    .acc_q_sel_i        (acc_q_sel_i),
    .acc_port_q_valid_o (acc_port_q_valid_o),
    .acc_port_q_ready_i (acc_port_q_ready_i)
  );

  offload_rsp_arbiter u_offload_rsp_arbiter (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .acc_port_p_valid_i (acc_port_p_valid_i),
    .acc_port_p_ready_o (acc_port_p_ready_o),
    .acc_port_p_id_i    (acc_port_p_id_i),
    .acc_port_p_data_i  (acc_port_p_data_i),
    .acc_port_p_error_i (acc_port_p_error_i),
    .acc_p_valid_o      (acc_p_valid_o),
    .acc_p_ready_i      (acc_p_ready_i),
    .acc_p_id_o         (acc_p_id_o),
    .acc_p_data_o       (acc_p_data_o),
    .acc_p_error_o      (acc_p_error_o)
  );

  // --------------------------------------------------------------------------
  // Data memory path
  // --------------------------------------------------------------------------
  data_addr_router u_data_addr_router (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tcdm_base_i    (tcdm_base_i),
    .mem_q_valid_i  (mem_q_valid_i),
    .mem_q_ready_o  (mem_q_ready_o),
    .mem_q_addr_i   (mem_q_addr_i),
    .mem_q_write_i  (mem_q_write_i),
    .mem_q_wdata_i  (mem_q_wdata_i),
    .mem_p_valid_o  (mem_p_valid_o),
    .mem_p_ready_i  (mem_p_ready_i),
    .mem_p_rdata_o  (mem_p_rdata_o),
    .tcdm_q_valid_o (tcdm_q_valid_o),
    .tcdm_q_ready_i (tcdm_q_ready_i),
    .tcdm_q_addr_o  (tcdm_q_addr_o),
    .tcdm_q_write_o (tcdm_q_write_o),
    .tcdm_q_wdata_o (tcdm_q_wdata_o),
    .tcdm_p_valid_i (tcdm_p_valid_i),
    .tcdm_p_ready_o (tcdm_p_ready_o),
    .tcdm_p_rdata_i (tcdm_p_rdata_i),
    .soc_q_valid_o  (soc_q_valid_o),
    .soc_q_ready_i  (soc_q_ready_i),
    .soc_q_addr_o   (soc_q_addr_o),
    .soc_q_write_o  (soc_q_write_o),
    .soc_q_wdata_o  (soc_q_wdata_o),
    .soc_p_valid_i  (soc_p_valid_i),
    .soc_p_ready_o  (soc_p_ready_o),
    .soc_p_rdata_i  (soc_p_rdata_i)
  );

endmodule

/* dv/tb_core_complex_fabric.sv */
// Core complex fabric testbench
// Drives offload and data streams, models accelerators and memories,
// checks steering, arbitration and response order against reference functions

`timescale 1ns/1ps

module tb_core_complex_fabric
  import cc_cfg_pkg::*;
  import cc_types_pkg::*;
();

  logic clk_i, rst_ni, acc_q_valid_i, acc_q_ready_o, acc_p_valid_o, acc_p_ready_i, acc_p_error_o;
  logic mem_q_valid_i, mem_q_ready_o, mem_q_write_i, mem_p_valid_o, mem_p_ready_i;
  addr_t tcdm_base_i, mem_q_addr_i, tcdm_q_addr_o, soc_q_addr_o;
  acc_sel_t acc_q_sel_i, rr_ptr;
  acc_id_t acc_q_id_i, acc_p_id_o;
  data_t acc_q_data_i, acc_p_data_o, mem_q_wdata_i, mem_p_rdata_o, tcdm_q_wdata_o, soc_q_wdata_o;
  logic [NumAccPorts-1:0] acc_port_q_valid_o, acc_port_q_ready_i, acc_port_p_valid_i;
  logic [NumAccPorts-1:0] acc_port_p_ready_o, acc_port_p_error_i;
  acc_id_t [NumAccPorts-1:0] acc_port_q_id_o, acc_port_p_id_i;
  data_t [NumAccPorts-1:0] acc_port_q_data_o, acc_port_p_data_i;
  // Memory sides indexed by mem_dst_e so 0 is SoC and 1 is TCDM
  logic [1:0] q_valid, q_ready, q_write, p_valid, p_ready, rsp_taken;
  data_t [1:0] p_rdata;
  data_t mem_arr [2][64];
  data_t ref_mem [2][64];
  data_t pend_q [2][$];
  data_t exp_q [$];
  int unsigned dly [2];
  logic stall;
  logic [15:0] lfsr_q;
  int err_cnt, test_cnt;

  core_complex_fabric UUT (.*, .tcdm_q_valid_o(q_valid[1]), .tcdm_q_ready_i(q_ready[1]),
    .tcdm_q_write_o(q_write[1]), .tcdm_p_valid_i(p_valid[1]), .tcdm_p_ready_o(p_ready[1]),
    .tcdm_p_rdata_i(p_rdata[1]), .soc_q_valid_o(q_valid[0]), .soc_q_ready_i(q_ready[0]),
    .soc_q_write_o(q_write[0]), .soc_p_valid_i(p_valid[0]), .soc_p_ready_o(p_ready[0]),
    .soc_p_rdata_i(p_rdata[0]));

  always #20 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] lfsr_take(input int unsigned nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // ---------------------------------------------------------------------------
  // Reference functions
  // ---------------------------------------------------------------------------
  function automatic logic [3:0] onehot_valid(input logic vld, input acc_sel_t sel);
    return vld ? (4'b0001 << sel) : 4'b0000;
  endfunction

  // Scanning downward and keeping the last hit gives the first hit upward
  function automatic acc_sel_t next_grant(input logic [3:0] vld, input acc_sel_t ptr);
    acc_sel_t idx;
    acc_sel_t res;
    res = ptr;
    for (int k = 3; k >= 0; k--) begin
      idx = ptr + acc_sel_t'(k);
      if (vld[idx]) res = idx;
    end
    return res;
  endfunction

  function automatic mem_dst_e decode_dst(input addr_t addr, input addr_t base);
    if ((addr >> TcdmAddrWidth) == (base >> TcdmAddrWidth)) return MEM_TCDM;
    if ((addr >> TcdmAddrWidth) == (TcdmAliasStart >> TcdmAddrWidth)) return MEM_TCDM;
    return MEM_SOC;
  endfunction

  function automatic data_t fill_word(input int side, input int idx);
    return 32'h1000_0000 * side ^ (32'h0101_0101 * idx) ^ 32'h00A5_5A00;
  endfunction

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int start_err);
    test_cnt++;
    if (err_cnt == start_err) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: errors", test_cnt, name);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Memory responders and the comparing process
  // ---------------------------------------------------------------------------
  always begin
    // Accepted requests and taken responses
    @(posedge clk_i);
    for (int s = 0; s < 2; s++) begin
      if (q_valid[s] && q_ready[s]) begin
        if (q_write[s]) begin
          mem_arr[s][(s ? tcdm_q_addr_o[7:2] : soc_q_addr_o[7:2])] =
            s ? tcdm_q_wdata_o : soc_q_wdata_o;
          pend_q[s].push_back('0);
        end else begin
          pend_q[s].push_back(mem_arr[s][(s ? tcdm_q_addr_o[7:2] : soc_q_addr_o[7:2])]);
        end
      end
      if (p_valid[s] && p_ready[s]) begin
        void'(pend_q[s].pop_front());
        rsp_taken[s] = 1'b1;
        dly[s] = lfsr_take(2);
      end
    end
    // Next response after its delay
    @(negedge clk_i);
    for (int s = 0; s < 2; s++) begin
      if (rsp_taken[s]) begin
        p_valid[s]   = 1'b0;
        rsp_taken[s] = 1'b0;
      end else if (!p_valid[s] && pend_q[s].size() > 0 && !stall) begin
        if (dly[s] == 0) begin
          p_valid[s] = 1'b1;
          p_rdata[s] = pend_q[s][0];
        end else begin
          dly[s]--;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    mem_dst_e d;
    if (!rst_ni && mem_q_valid_i && mem_q_ready_o) begin
      d = decode_dst(mem_q_addr_i, tcdm_base_i);
      if (q_valid != (d == MEM_TCDM ? 2'b10 : 2'b01) ||
          (d == MEM_TCDM ? tcdm_q_addr_o : soc_q_addr_o) != mem_q_addr_i ||
          q_write[d] != mem_q_write_i ||
          (d == MEM_TCDM ? tcdm_q_wdata_o : soc_q_wdata_o) != mem_q_wdata_i)
        report_fail($sformatf("address %h steered wrong", mem_q_addr_i));
      if (mem_q_write_i) begin
        ref_mem[d][mem_q_addr_i[7:2]] = mem_q_wdata_i;
        exp_q.push_back('0);
      end else begin
        exp_q.push_back(ref_mem[d][mem_q_addr_i[7:2]]);
      end
    end
    if (!rst_ni && mem_p_valid_o && mem_p_ready_i) begin
      if (exp_q.size() == 0) begin
        report_fail("response arrived with no request outstanding");
      end else if (mem_p_rdata_o != exp_q[0]) begin
        report_fail($sformatf("rdata %h, expected %h", mem_p_rdata_o, exp_q[0]));
        void'(exp_q.pop_front());
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Core side drivers
  // ---------------------------------------------------------------------------
  task automatic mem_issue(input addr_t addr, input logic wr, input data_t wdata);
    @(negedge clk_i);
    mem_q_valid_i = 1'b1;
    mem_q_addr_i  = addr;
    mem_q_write_i = wr;
    mem_q_wdata_i = wdata;
    do @(posedge clk_i); while (!mem_q_ready_o);
    @(negedge clk_i);
    mem_q_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic arb_round(input logic [3:0] set, input logic in_order);
    logic [3:0] pend;
    acc_sel_t   g;
    int         n;
    pend = set;
    n    = 0;
    for (int p = 0; p < NumAccPorts; p++) begin
      acc_port_p_id_i[p]    = acc_id_t'(lfsr_take(5));
      acc_port_p_data_i[p]  = lfsr_take(32);
      acc_port_p_error_i[p] = 1'(lfsr_take(1));
    end
    @(negedge clk_i);
    acc_port_p_valid_i = pend;
    while (pend != 0) begin
      @(posedge clk_i);
      g = next_grant(pend, rr_ptr);
      if (in_order && g != acc_sel_t'(n))
        report_fail($sformatf("grant %0d, expected port %0d", g, n));
      if (!acc_p_valid_o || acc_p_id_o != acc_port_p_id_i[g] ||
          acc_p_data_o != acc_port_p_data_i[g] || acc_p_error_o != acc_port_p_error_i[g] ||
          acc_port_p_ready_o != (4'b0001 << g))
        report_fail($sformatf("response from port %0d not granted", g));
      rr_ptr  = g + 1'b1;
      pend[g] = 1'b0;
      n++;
      @(negedge clk_i);
      acc_port_p_valid_i = pend;
    end
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    int         e;
    addr_t      a;
    logic [3:0] rdy;
    clk_i              = 1'b0;
    rst_ni             = 1'b1;
    lfsr_q             = 16'd58284;
    stall              = 1'b0;
    err_cnt            = 0;
    test_cnt           = 0;
    rr_ptr             = '0;
    tcdm_base_i        = 32'h1000_0000;
    acc_q_valid_i      = 1'b0;
    acc_q_sel_i        = '0;
    acc_q_id_i         = '0;
    acc_q_data_i       = '0;
    acc_port_q_ready_i = '0;
    acc_port_p_valid_i = '0;
    acc_port_p_id_i    = '0;
    acc_port_p_data_i  = '0;
    acc_port_p_error_i = '0;
    acc_p_ready_i      = 1'b1;
    mem_q_valid_i      = 1'b0;
    mem_q_addr_i       = '0;
    mem_q_write_i      = 1'b0;
    mem_q_wdata_i      = '0;
    mem_p_ready_i      = 1'b1;
    q_ready            = 2'b11;
    p_valid            = '0;
    p_rdata            = '0;
    rsp_taken          = '0;
    dly[0]             = 0;
    dly[1]             = 0;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 64; i++) begin
        mem_arr[s][i] = fill_word(s, i);
        ref_mem[s][i] = fill_word(s, i);
      end
    end
    repeat (3) @(negedge clk_i);
    rst_ni  = 1'b0;
    // Both memory sides offer a response with nothing outstanding
    p_valid = 2'b11;

    e = err_cnt;
    @(posedge clk_i);
    if (acc_port_q_valid_o != 0 || acc_p_valid_o || mem_p_valid_o || q_valid != 0 ||
        p_ready != 0)
      report_fail("valid output high after reset");
    @(negedge clk_i);
    p_valid = '0;
    mem_issue(32'h8000_0010, 1'b0, '0);
    drain();
    end_test("reset and first request", e);

    e = err_cnt;
    for (int s = 0; s < NumAccPorts; s++) begin
      @(negedge clk_i);
      rdy                = 4'(lfsr_take(4));
      acc_q_valid_i      = 1'b1;
      acc_q_sel_i        = acc_sel_t'(s);
      acc_port_q_ready_i = rdy;
      acc_q_id_i         = acc_id_t'(lfsr_take(5));
      acc_q_data_i       = lfsr_take(32);
      @(posedge clk_i);
      if (acc_port_q_valid_o != onehot_valid(1'b1, acc_sel_t'(s)) ||
          acc_q_ready_o != rdy[s] || acc_port_q_id_o[s] != acc_q_id_i ||
          acc_port_q_data_o[s] != acc_q_data_i)
        report_fail($sformatf("offload to port %0d wrong", s));
    end
    @(negedge clk_i);
    acc_q_valid_i = 1'b0;
    end_test("offload steering", e);

    e = err_cnt;
    arb_round(4'hF, 1'b1);
    for (int r = 0; r < 8; r++) arb_round(4'(lfsr_take(4)), 1'b0);
    end_test("response arbitration", e);

    e = err_cnt;
    for (int r = 0; r < 12; r++) begin
      tcdm_base_i = lfsr_take(20) << TcdmAddrWidth;
      a = (r % 3 == 0) ? tcdm_base_i : (r % 3 == 1) ? TcdmAliasStart : lfsr_take(32);
      mem_issue(a + (lfsr_take(10) << 2), 1'b0, '0);
    end
    drain();
    end_test("address decode", e);

    e = err_cnt;
    tcdm_base_i = 32'h1000_0000;
    for (int r = 0; r < 16; r++) begin
      a = lfsr_take(1) ? 32'h1000_0000 : 32'h8000_0000;
      mem_issue(a + (lfsr_take(3) << 2), lfsr_take(2) == 0, lfsr_take(32));
    end
    drain();
    end_test("in-order responses", e);

    e = err_cnt;
    stall = 1'b1;
    for (int r = 0; r < 4; r++) mem_issue(32'h1000_0000 + r * 4 * (r % 2), 1'b0, '0);
    @(negedge clk_i);
    mem_q_valid_i = 1'b1;
    mem_q_addr_i  = 32'h8000_0040;
    repeat (3) begin
      @(posedge clk_i);
      if (mem_q_ready_o || q_valid != 0) report_fail("fifth request accepted while full");
    end
    stall = 1'b0;
    do @(posedge clk_i); while (!mem_q_ready_o);
    @(negedge clk_i);
    mem_q_valid_i = 1'b0;
    drain();
    end_test("outstanding limit", e);

    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog over the total test length with margin
  initial begin
    repeat (2000) @(posedge clk_i);
    $display("Timeout: the tests did not complete within 2000 cycles");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* sim.f */
hdl/cc_cfg_pkg.sv
hdl/cc_types_pkg.sv
hdl/offload_demux.sv
hdl/offload_rsp_arbiter.sv
hdl/data_addr_router.sv
hdl/core_complex_fabric.sv
dv/tb_core_complex_fabric.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fabric testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f \
  --top-module tb_core_complex_fabric -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
